// File: audio_pkg.sv
`default_nettype none

package audio_pkg;

    // ==============================
    // channels and samples
    // ==============================
    localparam int NUM_CH     = 2;
    localparam int HIST_DEPTH = 4;

    typedef logic signed [23:0] sample_t;

    // one strobe bit per channel.
    typedef logic [NUM_CH-1:0] ch_mask_t;

    // ==============================
    // rate select
    // ==============================
    // one-hot, bit positions below.
    typedef logic [2:0] rate_sel_t;

    localparam int RATE_48  = 0;
    localparam int RATE_96  = 1;
    localparam int RATE_192 = 2;

endpackage

`default_nettype wire

// File: mult_pkg.sv
`default_nettype none

package mult_pkg;

    // ==============================
    // operand and product widths
    // ==============================
    typedef logic signed [23:0] mcand_t;

    // Q15 coefficient.
    typedef logic signed [15:0] mplier_t;

    // product shifted down by 15 bits.
    typedef logic signed [23:0] mprod_t;

    // ==============================
    // pipeline and schedule
    // ==============================
    localparam int MULT_LATENCY = 2;
    localparam int SCHED_SLOT   = 42;
    localparam int NUM_STAGES   = 2;

    // ==============================
    // interpolator taps
    // ==============================
    typedef mplier_t [3:0] coef_t;

    // taps sum to 32768, so dc passes unchanged.
    localparam coef_t INTERP_COEF = '{
        -16'sd2048,
        16'sd18432,
        16'sd18432,
        -16'sd2048
    };

endpackage

`default_nettype wire

// File: mult_bus_if.sv
`default_nettype none

interface mult_bus_if;

    // high while the stage owns the multiplier.
    logic grant;

    // operands are zero outside the slot.
    mult_pkg::mcand_t  mcand;
    mult_pkg::mplier_t mplier;

    // product of the operands MULT_LATENCY cycles back.
    mult_pkg::mprod_t  mprod;

    modport stage (
        input  grant,
        output mcand,
        output mplier,
        input  mprod
    );

    modport sched (
        output grant,
        input  mcand,
        input  mplier,
        output mprod
    );

endinterface

`default_nettype wire

// File: mult_sched.sv
`default_nettype none

module mult_sched (
    input wire        clk,
    input wire        rst_i,
    mult_bus_if.sched stages [mult_pkg::NUM_STAGES]
);

    import mult_pkg::*;

    localparam int CNT_W = $clog2(SCHED_SLOT);

    logic [CNT_W-1:0]      slot_cnt_q;
    logic [NUM_STAGES-1:0] grant_q;

    mcand_t  cand_vec  [NUM_STAGES];
    mplier_t plier_vec [NUM_STAGES];
    mcand_t  cand_or;
    mplier_t plier_or;

    mcand_t               op_cand_q;
    mplier_t              op_plier_q;
    logic signed [39:0]   full_prod;
    mprod_t               prod_q;

    // ==============================
    // slot rotation
    // ==============================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            slot_cnt_q <= '0;
            grant_q    <= NUM_STAGES'(1);
        end else if (slot_cnt_q == CNT_W'(SCHED_SLOT - 1)) begin
            slot_cnt_q <= '0;
            grant_q    <= {grant_q[NUM_STAGES-2:0], grant_q[NUM_STAGES-1]};
        end else begin
            slot_cnt_q <= slot_cnt_q + 1'b1;
        end
    end

    for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
        assign stages[g].grant = grant_q[g];
        assign stages[g].mprod = prod_q;
        assign cand_vec[g]     = stages[g].mcand;
        assign plier_vec[g]    = stages[g].mplier;

        // idle stages keep the shared bus quiet.
        a_idle_zero: assert property (@(posedge clk) disable iff (rst_i)
            !grant_q[g] |-> (stages[g].mcand == '0 && stages[g].mplier == '0));
    end

    // idle stages drive zero, so OR works as a mux.
    always_comb begin
        cand_or  = '0;
        plier_or = '0;
        for (int i = 0; i < NUM_STAGES; i++) begin
            cand_or  = cand_or | cand_vec[i];
            plier_or = plier_or | plier_vec[i];
        end
    end

    // ==============================
    // two-stage multiplier
    // ==============================
    assign full_prod = op_cand_q * op_plier_q;

    always_ff @(posedge clk) begin
        op_cand_q  <= cand_or;
        op_plier_q <= plier_or;
        prod_q     <= full_prod[38:15];
    end

endmodule

`default_nettype wire

// File: sample_ring.sv
`default_nettype none

module sample_ring (
    input  wire                                         clk,
    input  wire                                         rst_i,
    input  wire                                         wr_en_i,
    input  wire [$clog2(audio_pkg::NUM_CH)-1:0]         wr_ch_i,
    input  wire audio_pkg::sample_t                     wr_data_i,
    input  wire [$clog2(audio_pkg::NUM_CH)-1:0]         rd_ch_i,
    input  wire [$clog2(audio_pkg::HIST_DEPTH)-1:0]     rd_idx_i,
    output audio_pkg::sample_t                          rd_data_o,
    output audio_pkg::sample_t                          hist_o
);

    import audio_pkg::*;

    localparam int PTR_W = $clog2(HIST_DEPTH);

    sample_t          hist_q   [NUM_CH][HIST_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q [NUM_CH];
    logic [PTR_W-1:0] rd_ptr;

    // ==============================
    // history write
    // ==============================
    // write pointer also marks the oldest entry.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int c = 0; c < NUM_CH; c++) begin
                wr_ptr_q[c] <= '0;
                for (int t = 0; t < HIST_DEPTH; t++) begin
                    hist_q[c][t] <= '0;
                end
            end
        end else if (wr_en_i) begin
            hist_q[wr_ch_i][wr_ptr_q[wr_ch_i]] <= wr_data_i;
            wr_ptr_q[wr_ch_i]                  <= wr_ptr_q[wr_ch_i] + 1'b1;
        end
    end

    // ==============================
    // tap read
    // ==============================
    // tap 0 is the oldest, the pointer wraps.
    assign rd_ptr = wr_ptr_q[rd_ch_i] + rd_idx_i;
    assign hist_o = hist_q[rd_ch_i][rd_ptr];

    // registered copy for the direct sample return.
    always_ff @(posedge clk) begin
        rd_data_o <= hist_o;
    end

endmodule

`default_nettype wire

// File: upsample2x.sv
`default_nettype none

module upsample2x (
    input  wire                    clk,
    input  wire                    rst_i,
    mult_bus_if.stage              mult,
    output audio_pkg::ch_mask_t    pop_o,
    input  wire audio_pkg::sample_t data_i,
    input  wire audio_pkg::ch_mask_t ack_i,
    input  wire audio_pkg::ch_mask_t pop_i,
    output audio_pkg::sample_t     data_o,
    output audio_pkg::ch_mask_t    ack_o
);

    import audio_pkg::*;
    import mult_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_EVEN,
        S_WAIT,
        S_MAC,
        S_ODD
    } state_t;

    state_t             state_q;
    logic               cur_ch_q;
    logic               last_ch_q;
    logic [2:0]         cnt_q;
    ch_mask_t           phase_q;
    ch_mask_t           wait_q;
    ch_mask_t           pend_q;
    logic               grant_q;
    logic signed [25:0] acc_q;

    ch_mask_t           req;
    logic               sel_ch;
    logic               rd_ch;
    logic [1:0]         rd_idx;
    logic               issue;
    logic               start;
    ch_mask_t           cur_mask;
    ch_mask_t           busy;
    sample_t            ring_data;
    sample_t            ring_tap;

    // ==============================
    // request arbitration
    // ==============================
    assign req      = pend_q | pop_i;
    assign sel_ch   = (req[0] && req[1]) ? ~last_ch_q : req[1];
    assign cur_mask = ch_mask_t'(1) << cur_ch_q;
    assign busy     = pend_q | ((state_q != S_IDLE) ? cur_mask : '0);

    // odd phase starts only at a slot boundary.
    assign start = (state_q == S_WAIT) && mult.grant && !grant_q && !wait_q[cur_ch_q];
    assign issue = (state_q == S_MAC) && (cnt_q < 3'd4);

    // even phase reads tap 2, the center once the new sample lands.
    assign rd_ch  = (state_q == S_IDLE) ? sel_ch : cur_ch_q;
    assign rd_idx = issue ? cnt_q[1:0] : 2'd2;

    sample_ring i_sample_ring (
        .clk       (clk),
        .rst_i     (rst_i),
        .wr_en_i   (|ack_i),
        .wr_ch_i   (ack_i[1]),
        .wr_data_i (data_i),
        .rd_ch_i   (rd_ch),
        .rd_idx_i  (rd_idx),
        .rd_data_o (ring_data),
        .hist_o    (ring_tap)
    );

    assign mult.mcand  = issue ? ring_tap : '0;
    assign mult.mplier = issue ? INTERP_COEF[cnt_q[1:0]] : '0;

    // ==============================
    // phase FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= S_IDLE;
            cur_ch_q  <= 1'b0;
            last_ch_q <= 1'b1;
            cnt_q     <= '0;
            phase_q   <= '0;
            wait_q    <= '0;
            pend_q    <= '0;
            grant_q   <= 1'b0;
        end else begin
            grant_q <= mult.grant;
            pend_q  <= pend_q | pop_i;
            wait_q  <= wait_q & ~ack_i;
            case (state_q)
                S_IDLE: begin
                    if (|req) begin
                        cur_ch_q  <= sel_ch;
                        last_ch_q <= sel_ch;
                        pend_q    <= req & ~(ch_mask_t'(1) << sel_ch);
                        phase_q   <= phase_q ^ (ch_mask_t'(1) << sel_ch);
                        state_q   <= phase_q[sel_ch] ? S_WAIT : S_EVEN;
                    end
                end
                S_EVEN: begin
                    // fetch the next upstream sample with the ack.
                    wait_q  <= (wait_q & ~ack_i) | cur_mask;
                    state_q <= S_IDLE;
                end
                S_WAIT: begin
                    cnt_q <= '0;
                    if (start) begin
                        state_q <= S_MAC;
                    end
                end
                S_MAC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == 3'(MULT_LATENCY + 3)) begin
                        state_q <= S_ODD;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // products land MULT_LATENCY cycles after each issue.
    always_ff @(posedge clk) begin
        if (start) begin
            acc_q <= '0;
        end else if (state_q == S_MAC && cnt_q >= 3'(MULT_LATENCY)) begin
            acc_q <= acc_q + mult.mprod;
        end
    end

    // ==============================
    // outputs
    // ==============================
    assign pop_o  = (state_q == S_EVEN) ? cur_mask : '0;
    assign ack_o  = (state_q == S_EVEN || state_q == S_ODD) ? cur_mask : '0;
    assign data_o = (state_q == S_EVEN) ? ring_data : sample_t'(acc_q[23:0]);

    for (genvar c = 0; c < NUM_CH; c++) begin : g_chk
        a_no_double_pop: assert property (@(posedge clk) disable iff (rst_i)
            pop_i[c] |-> !busy[c]);
    end

endmodule

`default_nettype wire

// File: resample_pipeline.sv
`default_nettype none

module resample_pipeline (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire audio_pkg::rate_sel_t rate_i,
    output logic [1:0]           pop_o,
    input  wire [23:0]           data_i,
    input  wire [1:0]            ack_i,
    input  wire [1:0]            pop_i,
    output logic [23:0]          data_o,
    output logic [1:0]           ack_o
);

    import audio_pkg::*;
    import mult_pkg::*;

    mult_bus_if bus [NUM_STAGES] ();

    ch_mask_t pop_o_48;
    ch_mask_t ack_i_48;
    ch_mask_t pop_i_48;
    sample_t  data_o_96;
    ch_mask_t ack_o_96;

    ch_mask_t pop_o_96;
    sample_t  data_i_96;
    ch_mask_t ack_i_96;
    ch_mask_t pop_i_96;
    sample_t  data_o_192;
    ch_mask_t ack_o_192;

    mult_sched i_mult_sched (
        .clk    (clk),
        .rst_i  (rst_i),
        .stages (bus)
    );

    // ==============================
    // 48 to 96
    // ==============================
    // first stage is idle unless the input runs at 48k.
    assign ack_i_48 = rate_i[RATE_48] ? ack_i : '0;
    assign pop_i_48 = rate_i[RATE_48] ? pop_o_96 : '0;

    upsample2x ups_48to96 (
        .clk    (clk),
        .rst_i  (rst_i),
        .mult   (bus[0]),
        .pop_o  (pop_o_48),
        .data_i (data_i),
        .ack_i  (ack_i_48),
        .pop_i  (pop_i_48),
        .data_o (data_o_96),
        .ack_o  (ack_o_96)
    );

    // ==============================
    // 96 to 192
    // ==============================
    assign data_i_96 = rate_i[RATE_96] ? data_i : data_o_96;
    assign ack_i_96  = rate_i[RATE_96] ? ack_i : ack_o_96;
    assign pop_i_96  = rate_i[RATE_192] ? '0 : pop_i;

    upsample2x ups_96to192 (
        .clk    (clk),
        .rst_i  (rst_i),
        .mult   (bus[1]),
        .pop_o  (pop_o_96),
        .data_i (data_i_96),
        .ack_i  (ack_i_96),
        .pop_i  (pop_i_96),
        .data_o (data_o_192),
        .ack_o  (ack_o_192)
    );

    // ==============================
    // output and upstream select
    // ==============================
    // 192k passes straight through.
    assign data_o = rate_i[RATE_192] ? data_i : data_o_192;
    assign ack_o  = rate_i[RATE_192] ? ack_i : ack_o_192;

    always_comb begin
        if (rate_i[RATE_192]) begin
            pop_o = pop_i;
        end else if (rate_i[RATE_96]) begin
            pop_o = pop_o_96;
        end else begin
            pop_o = pop_o_48;
        end
    end

endmodule

`default_nettype wire

// File: tb_resample_pipeline.sv
`default_nettype none

module tb_resample_pipeline;

    import audio_pkg::*;
    import mult_pkg::*;

    localparam int MODE_NONE  = 0;
    localparam int MODE_CONST = 1;
    localparam int MODE_RAMP  = 2;

    // outputs per channel in each test.
    localparam int N_192  = 16;
    localparam int N_96   = 16;
    localparam int N_48   = 28;
    localparam int N_RAMP = 20;

    // three schedule periods per output covers the 48k chain, plus the request gap.
    localparam int CYC_PER_OUT = 6 * SCHED_SLOT + 16;
    localparam int CYC_LIMIT   = NUM_CH * (N_192 + N_96 + N_48 + N_RAMP) * CYC_PER_OUT + 500;

    logic      clk;
    logic      rst_i;
    rate_sel_t rate_i;
    ch_mask_t  pop_o;
    sample_t   data_i = '0;
    ch_mask_t  ack_i  = '0;
    ch_mask_t  pop_i;
    sample_t   data_o;
    ch_mask_t  ack_o;

    logic [31:0] lfsr_q;
    int          cyc_cnt   = 0;
    int          err_cnt   = 0;
    int          tests_ok  = 0;
    int          tests_bad = 0;
    string       cur_test;
    int          chk_mode;
    int          skip_n;

    sample_t  src_base [NUM_CH];
    sample_t  src_step [NUM_CH];
    int       src_idx  [NUM_CH];
    ch_mask_t src_pend;
    ch_mask_t src_want;

    int       ack_cnt  [NUM_CH];
    int       up_pops  [NUM_CH];
    sample_t  last_out [NUM_CH];
    ch_mask_t owed;

    logic     ack_ch;
    logic     val_chk;
    sample_t  exp_val;

    resample_pipeline i_resample_pipeline (
        .clk    (clk),
        .rst_i  (rst_i),
        .rate_i (rate_i),
        .pop_o  (pop_o),
        .data_i (data_i),
        .ack_i  (ack_i),
        .pop_i  (pop_i),
        .data_o (data_o),
        .ack_o  (ack_o)
    );

    always #2 clk = ~clk;

    function automatic int rand_bits(input int nbits);
        int r;
        r = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
            r      = (r << 1) | int'(lfsr_q[0]);
        end
        return r;
    endfunction

    task automatic note_fail(input logic [31:0] expected, input logic [31:0] actual);
        $display("FAIL %s expected %h actual %h", cur_test, expected, actual);
        err_cnt++;
    endtask

    task automatic note_error(input string msg);
        $display("ERROR in %s: %s", cur_test, msg);
        err_cnt++;
    endtask

    // ==============================
    // upstream source and scoreboard
    // ==============================
    // answers one pop per cycle, next value of that channel's sequence.
    always @(posedge clk) begin
        if (rst_i) begin
            src_want = '0;
            for (int c = 0; c < NUM_CH; c++) begin
                src_idx[c] = 0;
            end
        end else begin
            src_want = src_pend | pop_o;
        end
        #1;
        ack_i = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (src_want[c] && ack_i == '0) begin
                ack_i[c]    = 1'b1;
                data_i      = src_base[c] + src_step[c] * src_idx[c];
                src_idx[c]  = src_idx[c] + 1;
                src_want[c] = 1'b0;
            end
        end
        src_pend = src_want;
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (rst_i) begin
            owed <= '0;
            for (int c = 0; c < NUM_CH; c++) begin
                ack_cnt[c]  <= 0;
                up_pops[c]  <= 0;
                last_out[c] <= '0;
            end
        end else begin
            owed <= (owed | pop_i) & ~ack_o;
            for (int c = 0; c < NUM_CH; c++) begin
                if (pop_o[c]) begin
                    up_pops[c] <= up_pops[c] + 1;
                end
                if (ack_o[c]) begin
                    ack_cnt[c]  <= ack_cnt[c] + 1;
                    last_out[c] <= data_o;
                end
            end
        end
        if (cyc_cnt >= CYC_LIMIT) begin
            $display("ERROR: timeout after %0d cycles in %s, an ack never came", cyc_cnt,
                     cur_test);
            $display("TEST FAIL");
            $finish;
        end
    end

    // linear input gives the exact midpoint, so the step halves.
    always_comb begin
        ack_ch  = ack_o[1];
        exp_val = (chk_mode == MODE_RAMP) ? last_out[ack_ch] + (src_step[ack_ch] >>> 1)
                                          : src_base[ack_ch];
        val_chk = (chk_mode != MODE_NONE) && (ack_o != '0) && (ack_cnt[ack_ch] >= skip_n);
    end

    // ==============================
    // assertions
    // ==============================
    a_reset_quiet: assert property (@(posedge clk) $past(rst_i) |-> (pop_o == '0 && ack_o == '0))
        else note_error("pop_o or ack_o active during or right after reset");

    a_bypass: assert property (@(posedge clk) disable iff (rst_i)
        rate_i[RATE_192] |-> ({pop_o, ack_o, data_o} == {pop_i, ack_i, data_i}))
        else note_fail($sampled({pop_i, ack_i, data_i}), $sampled({pop_o, ack_o, data_o}));

    a_value: assert property (@(posedge clk) disable iff (rst_i) val_chk |-> data_o == exp_val)
        else note_fail($sampled(exp_val), $sampled(data_o));

    a_ack_onehot: assert property (@(posedge clk) disable iff (rst_i) $onehot0(ack_o))
        else note_error("ack_o has both channel bits set");

    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        a_ack_owed: assert property (@(posedge clk) disable iff (rst_i) ack_o[c] |-> owed[c])
            else note_error($sformatf("channel %0d acked without an outstanding pop", c));

        a_isolated: assert property (@(posedge clk) disable iff (rst_i)
            (chk_mode == MODE_CONST && ack_o[c]) |-> data_o != src_base[1-c])
            else note_error($sformatf("channel %0d returned the other channel's value", c));
    end

    // ==============================
    // stimulus
    // ==============================
    task automatic apply_reset(input int rate_bit);
        #1;
        rst_i  = 1'b1;
        rate_i = rate_sel_t'(1) << rate_bit;
        pop_i  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_i = 1'b0;
    endtask

    task automatic request_channel(input int ch, input int n);
        int gap;
        for (int k = 0; k < n; k++) begin
            gap = rand_bits(4);
            repeat (gap) @(posedge clk);
            @(posedge clk);
            #1;
            pop_i[ch] = 1'b1;
            @(posedge clk);
            #1;
            pop_i[ch] = 1'b0;
            while (ack_cnt[ch] <= k) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic run_test(input string name, input int rate_bit, input int mode, input int n);
        int errs_before;
        int want;
        int tol;
        errs_before = err_cnt;
        cur_test    = name;
        chk_mode    = mode;
        // history fills after six outputs per stage, eighteen through both.
        skip_n      = (rate_bit == RATE_48) ? 18 : ((mode == MODE_RAMP) ? 7 : 6);
        for (int c = 0; c < NUM_CH; c++) begin
            src_step[c] = (mode == MODE_CONST) ? '0 : sample_t'((rand_bits(4) + 1) * 16);
        end
        apply_reset(rate_bit);
        fork
            request_channel(0, n);
            request_channel(1, n);
        join
        repeat (8) @(posedge clk);
        for (int c = 0; c < NUM_CH; c++) begin
            if (rate_bit == RATE_192) begin
                want = ack_cnt[c];
                tol  = 0;
            end else if (rate_bit == RATE_96) begin
                want = ack_cnt[c] / 2;
                tol  = 1;
            end else begin
                want = ack_cnt[c] / 4;
                tol  = 2;
            end
            assert (up_pops[c] >= want - tol && up_pops[c] <= want + tol)
                else note_fail(want, up_pops[c]);
        end
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("test %-12s passed", name);
        end else begin
            tests_bad++;
            $display("test %-12s failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        rate_i      = rate_sel_t'(1) << RATE_96;
        pop_i       = '0;
        lfsr_q      = 32'he884;
        cur_test    = "startup";
        chk_mode    = MODE_NONE;
        skip_n      = 0;
        // multiples of 16 keep every product exact.
        src_base[0] = 24'sh123450;
        src_base[1] = -24'sh0abcd0;
        src_step[0] = '0;
        src_step[1] = '0;

        run_test("reset_state", RATE_96, MODE_NONE, 0);
        run_test("bypass_192", RATE_192, MODE_NONE, N_192);
        run_test("const_96", RATE_96, MODE_CONST, N_96);
        run_test("const_48", RATE_48, MODE_CONST, N_48);
        run_test("ramp_96", RATE_96, MODE_RAMP, N_RAMP);

        $display("summary: %0d passed, %0d failed", tests_ok, tests_bad);
        if (tests_bad == 0 && err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
audio_pkg.sv
mult_pkg.sv
mult_bus_if.sv
mult_sched.sv
sample_ring.sv
upsample2x.sv
resample_pipeline.sv
tb_resample_pipeline.sv
